// ==== Makefile ====
TOP := dec_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module dec

sim:
	verilator --binary --timing -f files.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir

// ==== files.f ====
source/dec_pkg.sv
source/dec_slot_if.sv
source/dec_ib_ctl.sv
source/dec_decode_ctl.sv
source/dec_gpr_ctl.sv
source/dec_trace_ctl.sv
source/dec.sv
verif/dec_tb.sv

// ==== source/dec.sv ====
/*
 * Decode unit top: instruction buffer, decode with gpr read, trace.
 * Single clock, no stall; writebacks come straight from the ports.
 */
`timescale 1ns/10ps
`default_nettype none

module dec (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               exu_flush_final,

   input  logic               ifu_i0_valid,
   input  logic               ifu_i1_valid,
   input  logic               ifu_i0_icaf,
   input  logic               ifu_i1_icaf,
   input  dec_pkg::instr_t    ifu_i0_instr,
   input  dec_pkg::instr_t    ifu_i1_instr,
   input  dec_pkg::pc_t       ifu_i0_pc,
   input  dec_pkg::pc_t       ifu_i1_pc,

   input  logic               dec_i0_wen_wb,            // slot 0 writeback
   input  dec_pkg::reg_addr_t dec_i0_waddr_wb,
   input  dec_pkg::data_t     dec_i0_wdata_wb,
   input  logic               dec_i1_wen_wb,            // slot 1 writeback
   input  dec_pkg::reg_addr_t dec_i1_waddr_wb,
   input  dec_pkg::data_t     dec_i1_wdata_wb,
   input  logic               dec_nonblock_load_wen,    // load return, top priority
   input  dec_pkg::reg_addr_t dec_nonblock_load_waddr,
   input  dec_pkg::data_t     lsu_nonblock_load_data,

   output logic               dec_i0_valid_d,
   output logic               dec_i1_valid_d,
   output dec_pkg::reg_addr_t dec_i0_rd_d,
   output dec_pkg::reg_addr_t dec_i1_rd_d,
   output dec_pkg::data_t     dec_i0_immed_d,
   output dec_pkg::data_t     dec_i1_immed_d,

   output dec_pkg::data_t     gpr_i0_rs1_d,
   output dec_pkg::data_t     gpr_i0_rs2_d,
   output dec_pkg::data_t     gpr_i1_rs1_d,
   output dec_pkg::data_t     gpr_i1_rs2_d,

   output logic [1:0]         trace_valid,
   output logic [1:0]         trace_exception,
   output dec_pkg::instr_t    trace_insn0,
   output dec_pkg::instr_t    trace_insn1,
   output dec_pkg::data_t     trace_addr0,
   output dec_pkg::data_t     trace_addr1,
   output dec_pkg::ecause_t   trace_ecause,
   output dec_pkg::data_t     trace_tval
);

   dec_pkg::reg_addr_t rs1_addr [2];
   dec_pkg::reg_addr_t rs2_addr [2];
   logic [1:0]         rs1_en;
   logic [1:0]         rs2_en;
   dec_pkg::ecause_t   exc_cause [2];   // decode to trace
   dec_pkg::reg_addr_t gpr_raddr [4];
   dec_pkg::data_t     gpr_rd [4];

   dec_slot_if ib0 ();                  // buffer to decode
   dec_slot_if ib1 ();
   dec_slot_if td0 ();                  // decode to trace
   dec_slot_if td1 ();

   // read port order: i0 rs1, i0 rs2, i1 rs1, i1 rs2
   assign gpr_raddr[0] = rs1_addr[0];
   assign gpr_raddr[1] = rs2_addr[0];
   assign gpr_raddr[2] = rs1_addr[1];
   assign gpr_raddr[3] = rs2_addr[1];
   assign gpr_i0_rs1_d = gpr_rd[0];
   assign gpr_i0_rs2_d = gpr_rd[1];
   assign gpr_i1_rs1_d = gpr_rd[2];
   assign gpr_i1_rs2_d = gpr_rd[3];

   dec_ib_ctl instbuff (
      .clk, .rst_n, .exu_flush_final,
      .ifu_i0_valid, .ifu_i1_valid, .ifu_i0_icaf, .ifu_i1_icaf,
      .ifu_i0_instr, .ifu_i1_instr, .ifu_i0_pc, .ifu_i1_pc,
      .ib0 (ib0), .ib1 (ib1)
   );

   dec_decode_ctl decode (
      .ib0 (ib0), .ib1 (ib1),
      .rs1_addr, .rs2_addr, .rs1_en, .rs2_en,
      .dec_i0_valid_d, .dec_i1_valid_d, .dec_i0_rd_d, .dec_i1_rd_d,
      .dec_i0_immed_d, .dec_i1_immed_d,
      .td0 (td0), .td1 (td1), .exc_cause
   );

   dec_gpr_ctl arf (
      .clk, .rst_n,
      .raddr  (gpr_raddr),
      .rden   ({rs2_en[1], rs1_en[1], rs2_en[0], rs1_en[0]}),
      .rd     (gpr_rd),
      .wen0   (dec_i0_wen_wb),         .waddr0 (dec_i0_waddr_wb),
      .wd0    (dec_i0_wdata_wb),
      .wen1   (dec_i1_wen_wb),         .waddr1 (dec_i1_waddr_wb),
      .wd1    (dec_i1_wdata_wb),
      .wen2   (dec_nonblock_load_wen), .waddr2 (dec_nonblock_load_waddr),
      .wd2    (lsu_nonblock_load_data)
   );

   dec_trace_ctl trace (
      .clk, .rst_n, .exu_flush_final,
      .td0 (td0), .td1 (td1), .exc_cause,
      .trace_valid, .trace_exception, .trace_insn0, .trace_insn1,
      .trace_addr0, .trace_addr1, .trace_ecause, .trace_tval
   );

endmodule

`default_nettype wire

// ==== source/dec_decode_ctl.sv ====
/*
 * RV32I decode of both slots, purely combinational.
 * Excepting slots stay valid so that trace reports them.
 */
`timescale 1ns/10ps
`default_nettype none

module dec_decode_ctl (
   dec_slot_if.dec             ib0,              // from instruction buffer
   dec_slot_if.dec             ib1,

   output dec_pkg::reg_addr_t  rs1_addr [2],     // per slot gpr read addresses
   output dec_pkg::reg_addr_t  rs2_addr [2],
   output logic [1:0]          rs1_en,           // per slot read enables
   output logic [1:0]          rs2_en,

   output logic                dec_i0_valid_d,
   output logic                dec_i1_valid_d,
   output dec_pkg::reg_addr_t  dec_i0_rd_d,      // destination, 0 if none
   output dec_pkg::reg_addr_t  dec_i1_rd_d,
   output dec_pkg::data_t      dec_i0_immed_d,   // sign extended immediate
   output dec_pkg::data_t      dec_i1_immed_d,

   dec_slot_if.ib              td0,              // to trace, icaf = exception
   dec_slot_if.ib              td1,
   output dec_pkg::ecause_t    exc_cause [2]     // cause beside each td slot
);

   dec_pkg::instr_t    insn [2];   // per slot instruction
   logic [1:0]         icaf;       // per slot fetch fault
   logic [1:0]         legal;      // opcode recognized
   logic [1:0]         exc;        // slot takes an exception
   dec_pkg::reg_addr_t rd [2];
   dec_pkg::data_t     imm [2];

   assign insn[0] = ib0.instr;
   assign insn[1] = ib1.instr;
   assign icaf    = {ib1.icaf, ib0.icaf};

   // ********************
   // per slot decode
   always_comb begin
      for (int s = 0; s < 2; s++) begin
         legal[s]    = 1'b0;
         rs1_en[s]   = 1'b0;
         rs2_en[s]   = 1'b0;
         rs1_addr[s] = insn[s][19:15];
         rs2_addr[s] = insn[s][24:20];
         rd[s]       = insn[s][11:7];
         imm[s]      = '0;
         // enum members all end in 11, so a match also checks bits 1:0
         case (insn[s][6:0])
            dec_pkg::op_lui, dec_pkg::op_auipc: begin
               legal[s] = 1'b1;
               imm[s]   = {insn[s][31:12], 12'b0};  // U format
            end
            dec_pkg::op_jal: begin
               legal[s] = 1'b1;
               imm[s]   = {{12{insn[s][31]}}, insn[s][19:12], insn[s][20],
                           insn[s][30:21], 1'b0};   // J format
            end
            dec_pkg::op_jalr, dec_pkg::op_load, dec_pkg::op_op_imm,
            dec_pkg::op_system, dec_pkg::op_fence: begin
               legal[s]  = 1'b1;
               rs1_en[s] = 1'b1;
               imm[s]    = {{20{insn[s][31]}}, insn[s][31:20]};  // I format
               if (insn[s][6:0] == dec_pkg::op_fence) rd[s] = '0;
            end
            dec_pkg::op_branch: begin
               legal[s]  = 1'b1;
               rs1_en[s] = 1'b1;
               rs2_en[s] = 1'b1;
               rd[s]     = '0;
               imm[s]    = {{20{insn[s][31]}}, insn[s][7], insn[s][30:25],
                            insn[s][11:8], 1'b0};  // B format
            end
            dec_pkg::op_store: begin
               legal[s]  = 1'b1;
               rs1_en[s] = 1'b1;
               rs2_en[s] = 1'b1;
               rd[s]     = '0;
               imm[s]    = {{20{insn[s][31]}}, insn[s][31:25], insn[s][11:7]};  // S
            end
            dec_pkg::op_op: begin
               legal[s]  = 1'b1;
               rs1_en[s] = 1'b1;
               rs2_en[s] = 1'b1;                   // no immediate
            end
            default: ;                             // illegal, all zero
         endcase

         // access fault wins over illegal
         exc[s] = icaf[s] | ~legal[s];
         if (icaf[s])
            exc_cause[s] = dec_pkg::CAUSE_ICAF;
         else if (!legal[s])
            exc_cause[s] = dec_pkg::CAUSE_ILLEGAL;
         else
            exc_cause[s] = '0;
      end
   end

   // ********************
   // outputs
   assign dec_i0_valid_d = ib0.valid;
   assign dec_i1_valid_d = ib1.valid;
   assign dec_i0_rd_d    = rd[0];
   assign dec_i1_rd_d    = rd[1];
   assign dec_i0_immed_d = imm[0];
   assign dec_i1_immed_d = imm[1];

   assign td0.valid = ib0.valid;
   assign td0.instr = ib0.instr;
   assign td0.pc    = ib0.pc;
   assign td0.icaf  = exc[0];     // exception flag from here on
   assign td1.valid = ib1.valid;
   assign td1.instr = ib1.instr;
   assign td1.pc    = ib1.pc;
   assign td1.icaf  = exc[1];

endmodule

`default_nettype wire

// ==== source/dec_gpr_ctl.sv ====
/*
 * Register file, 4 combinational reads, 3 writes at the clock edge.
 * Same address priority: port 2 over port 1 over port 0. x0 is hardwired.
 */
`timescale 1ns/10ps
`default_nettype none

module dec_gpr_ctl (
   input  logic               clk,
   input  logic               rst_n,       // clears x1..x31

   input  dec_pkg::reg_addr_t raddr [4],   // i0 rs1, i0 rs2, i1 rs1, i1 rs2
   input  logic [3:0]         rden,
   output dec_pkg::data_t     rd [4],

   input  logic               wen0,        // i0 writeback
   input  logic               wen1,        // i1 writeback
   input  logic               wen2,        // nonblock load return
   input  dec_pkg::reg_addr_t waddr0,
   input  dec_pkg::reg_addr_t waddr1,
   input  dec_pkg::reg_addr_t waddr2,
   input  dec_pkg::data_t     wd0,
   input  dec_pkg::data_t     wd1,
   input  dec_pkg::data_t     wd2
);

   dec_pkg::data_t gpr [1:dec_pkg::NUM_REGS-1];  // no storage for x0

   // ********************
   // write, later statement wins
   always_ff @(posedge clk) begin
      for (int i = 1; i < dec_pkg::NUM_REGS; i++) begin
         if (!rst_n) begin
            gpr[i] <= '0;
         end else begin
            if (wen0 && waddr0 == dec_pkg::reg_addr_t'(i)) gpr[i] <= wd0;
            if (wen1 && waddr1 == dec_pkg::reg_addr_t'(i)) gpr[i] <= wd1;
            if (wen2 && waddr2 == dec_pkg::reg_addr_t'(i)) gpr[i] <= wd2;
         end
      end
   end

   // ********************
   // read, zero when disabled or x0
   always_comb begin
      for (int p = 0; p < 4; p++) begin
         rd[p] = (rden[p] && raddr[p] != '0) ? gpr[raddr[p]] : '0;
      end
   end

endmodule

`default_nettype wire

// ==== source/dec_ib_ctl.sv ====
/*
 * Instruction buffer, one pair deep, no back-pressure.
 * A slot 1 strobe without slot 0 is dropped to keep program order.
 */
`timescale 1ns/10ps
`default_nettype none

module dec_ib_ctl (
   input  logic            clk,
   input  logic            rst_n,            // sync, active low
   input  logic            exu_flush_final,  // kill the buffered pair

   input  logic            ifu_i0_valid,     // single cycle strobes
   input  logic            ifu_i1_valid,
   input  logic            ifu_i0_icaf,      // fetch access fault
   input  logic            ifu_i1_icaf,
   input  dec_pkg::instr_t ifu_i0_instr,
   input  dec_pkg::instr_t ifu_i1_instr,
   input  dec_pkg::pc_t    ifu_i0_pc,
   input  dec_pkg::pc_t    ifu_i1_pc,

   dec_slot_if.ib          ib0,              // to decode, slot 0
   dec_slot_if.ib          ib1               // to decode, slot 1
);

   // ********************
   // valids
   always_ff @(posedge clk) begin
      if (!rst_n || exu_flush_final) begin
         ib0.valid <= 1'b0;
         ib1.valid <= 1'b0;
      end else begin
         ib0.valid <= ifu_i0_valid;
         ib1.valid <= ifu_i1_valid & ifu_i0_valid;  // i1 only behind i0
      end
   end

   // ********************
   // payload, loaded on strobe only
   always_ff @(posedge clk) begin
      if (ifu_i0_valid) begin
         ib0.instr <= ifu_i0_instr;
         ib0.pc    <= ifu_i0_pc;
         ib0.icaf  <= ifu_i0_icaf;
      end
      if (ifu_i1_valid) begin
         ib1.instr <= ifu_i1_instr;
         ib1.pc    <= ifu_i1_pc;
         ib1.icaf  <= ifu_i1_icaf;
      end
   end

endmodule

`default_nettype wire

// ==== source/dec_pkg.sv ====
/*
 * Shared widths, opcodes and exception causes of the decode unit.
 * RV32I only; compressed encodings are not recognized.
 */
`default_nettype none

package dec_pkg;

   // ********************
   // widths
   localparam int XLEN        = 32;   // data word
   localparam int REG_ADDR_W  = 5;    // register number
   localparam int NUM_REGS    = 32;   // x0 .. x31
   localparam int TRACE_DELAY = 2;    // decode to trace, in cycles

   typedef logic [XLEN-1:0]       data_t;      // register value, immediate, tval
   typedef logic [31:0]           instr_t;     // full 32b instruction
   typedef logic [31:1]           pc_t;        // pc, bit 0 implied zero
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // gpr index
   typedef logic [4:0]            ecause_t;    // mcause encoding

   // ********************
   // major opcodes, low two bits always 11
   typedef enum logic [6:0] {
      op_lui    = 7'b0110111,
      op_auipc  = 7'b0010111,
      op_jal    = 7'b1101111,
      op_jalr   = 7'b1100111,
      op_branch = 7'b1100011,
      op_load   = 7'b0000011,
      op_store  = 7'b0100011,
      op_op_imm = 7'b0010011,
      op_op     = 7'b0110011,
      op_fence  = 7'b0001111,
      op_system = 7'b1110011
   } opcode_e;

   // ********************
   // exception causes
   localparam ecause_t CAUSE_ICAF    = 5'd1;  // instruction access fault
   localparam ecause_t CAUSE_ILLEGAL = 5'd2;  // illegal instruction

endpackage

`default_nettype wire

// ==== source/dec_slot_if.sv ====
/*
 * One instruction slot between stages. Between decode and trace the
 * icaf bit means "slot excepts"; the cause travels beside it.
 */
`timescale 1ns/10ps
`default_nettype none

interface dec_slot_if;

   logic            valid;  // slot holds an instruction
   dec_pkg::instr_t instr;  // instruction word
   dec_pkg::pc_t    pc;     // its address
   logic            icaf;   // fetch access fault, or exception after decode

   modport ib    (output valid, instr, pc, icaf);  // producer side
   modport dec   (input  valid, instr, pc, icaf);  // decode reads the buffer
   modport trace (input  valid, instr, pc, icaf);  // trace reads decode

endinterface

`default_nettype wire

// ==== source/dec_trace_ctl.sv ====
/*
 * Trace of the decoded pair, TRACE_DELAY cycles after decode.
 * Cause and tval belong to the older excepting slot; a flush empties the pipe.
 */
`timescale 1ns/10ps
`default_nettype none

module dec_trace_ctl (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             exu_flush_final,   // drop everything in flight

   dec_slot_if.trace        td0,               // decoded slot 0
   dec_slot_if.trace        td1,               // decoded slot 1
   input  dec_pkg::ecause_t exc_cause [2],

   output logic [1:0]       trace_valid,
   output logic [1:0]       trace_exception,
   output dec_pkg::instr_t  trace_insn0,
   output dec_pkg::instr_t  trace_insn1,
   output dec_pkg::data_t   trace_addr0,       // byte address, bit 0 zero
   output dec_pkg::data_t   trace_addr1,
   output dec_pkg::ecause_t trace_ecause,
   output dec_pkg::data_t   trace_tval
);

   logic [1:0]       in_vld;     // pair entering the pipe
   logic [1:0]       in_exc;
   dec_pkg::ecause_t in_cause;
   dec_pkg::data_t   in_tval;

   // stage 0 newest, last stage drives the outputs
   logic [dec_pkg::TRACE_DELAY-1:0][1:0]                  vld_q;
   logic [dec_pkg::TRACE_DELAY-1:0][1:0]                  exc_q;
   dec_pkg::instr_t  [dec_pkg::TRACE_DELAY-1:0][1:0]      insn_q;
   dec_pkg::pc_t     [dec_pkg::TRACE_DELAY-1:0][1:0]      pc_q;
   dec_pkg::ecause_t [dec_pkg::TRACE_DELAY-1:0]           cause_q;
   dec_pkg::data_t   [dec_pkg::TRACE_DELAY-1:0]           tval_q;

   assign in_vld = {td1.valid, td0.valid};
   assign in_exc = in_vld & {td1.icaf, td0.icaf};

   // ********************
   // pick the older excepting slot
   always_comb begin
      in_cause = '0;
      in_tval  = '0;
      if (in_exc[0]) begin
         in_cause = exc_cause[0];
         in_tval  = (exc_cause[0] == dec_pkg::CAUSE_ICAF) ? {td0.pc, 1'b0} : td0.instr;
      end else if (in_exc[1]) begin
         in_cause = exc_cause[1];
         in_tval  = (exc_cause[1] == dec_pkg::CAUSE_ICAF) ? {td1.pc, 1'b0} : td1.instr;
      end
   end

   // ********************
   // control shift
   always_ff @(posedge clk) begin
      if (!rst_n || exu_flush_final) begin
         vld_q <= '0;
         exc_q <= '0;
      end else begin
         vld_q <= {vld_q[dec_pkg::TRACE_DELAY-2:0], in_vld};
         exc_q <= {exc_q[dec_pkg::TRACE_DELAY-2:0], in_exc};
      end
   end

   // payload shift
   always_ff @(posedge clk) begin
      insn_q  <= {insn_q[dec_pkg::TRACE_DELAY-2:0], td1.instr, td0.instr};
      pc_q    <= {pc_q[dec_pkg::TRACE_DELAY-2:0], td1.pc, td0.pc};
      cause_q <= {cause_q[dec_pkg::TRACE_DELAY-2:0], in_cause};
      tval_q  <= {tval_q[dec_pkg::TRACE_DELAY-2:0], in_tval};
   end

   // ********************
   // outputs
   assign trace_valid     = vld_q[dec_pkg::TRACE_DELAY-1];
   assign trace_exception = exc_q[dec_pkg::TRACE_DELAY-1];
   assign trace_insn0     = insn_q[dec_pkg::TRACE_DELAY-1][0];
   assign trace_insn1     = insn_q[dec_pkg::TRACE_DELAY-1][1];
   assign trace_addr0     = {pc_q[dec_pkg::TRACE_DELAY-1][0], 1'b0};
   assign trace_addr1     = {pc_q[dec_pkg::TRACE_DELAY-1][1], 1'b0};
   // zero unless something excepts
   assign trace_ecause = (|trace_exception) ? cause_q[dec_pkg::TRACE_DELAY-1] : '0;
   assign trace_tval   = (|trace_exception) ? tval_q[dec_pkg::TRACE_DELAY-1] : '0;

endmodule

`default_nettype wire

// ==== verif/dec_tb.sv ====
/*
 * Lockstep testbench: inputs change at the falling edge, outputs are checked
 * at the falling edge against a model kept in step with the writes.
 * Random stimulus from a fixed seed, so every run is the same.
 */
`timescale 1ns/10ps
`default_nettype none

module dec_tb;

   typedef struct packed {
      dec_pkg::instr_t i0;
      dec_pkg::instr_t i1;
      dec_pkg::pc_t    pc0;
      dec_pkg::pc_t    pc1;
      logic            v1;    // slot 1 expected valid
      logic            f0;    // fetch faults
      logic            f1;
      int              due;   // cycle the result must show
   } pair_t;

   localparam logic [6:0] OPCODES [11] = '{dec_pkg::op_lui, dec_pkg::op_auipc,
      dec_pkg::op_jal, dec_pkg::op_jalr, dec_pkg::op_branch, dec_pkg::op_load,
      dec_pkg::op_store, dec_pkg::op_op_imm, dec_pkg::op_op, dec_pkg::op_fence,
      dec_pkg::op_system};

   logic clk, rst_n, exu_flush_final;
   logic ifu_i0_valid, ifu_i1_valid, ifu_i0_icaf, ifu_i1_icaf;
   dec_pkg::instr_t ifu_i0_instr, ifu_i1_instr;
   dec_pkg::pc_t ifu_i0_pc, ifu_i1_pc;
   logic dec_i0_wen_wb, dec_i1_wen_wb, dec_nonblock_load_wen;
   dec_pkg::reg_addr_t dec_i0_waddr_wb, dec_i1_waddr_wb, dec_nonblock_load_waddr;
   dec_pkg::data_t dec_i0_wdata_wb, dec_i1_wdata_wb, lsu_nonblock_load_data;
   logic dec_i0_valid_d, dec_i1_valid_d;
   dec_pkg::reg_addr_t dec_i0_rd_d, dec_i1_rd_d;
   dec_pkg::data_t dec_i0_immed_d, dec_i1_immed_d;
   dec_pkg::data_t gpr_i0_rs1_d, gpr_i0_rs2_d, gpr_i1_rs1_d, gpr_i1_rs2_d;
   logic [1:0] trace_valid, trace_exception;
   dec_pkg::instr_t trace_insn0, trace_insn1;
   dec_pkg::data_t trace_addr0, trace_addr1, trace_tval;
   dec_pkg::ecause_t trace_ecause;

   dec_pkg::data_t mregs [32];   // model register file
   pair_t dq [$];                // expected decode results
   pair_t tq [$];                // expected trace results
   int cyc = 0;                  // rising edges seen
   int mism = 0;                 // wrong values
   int other = 0;                // missing or unexpected results

   dec UUT (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;     // 8 ns period
   end

   // ********************
   // compare tasks
   task automatic check_data(input string name, input dec_pkg::data_t got,
                             input dec_pkg::data_t exp);
      if (got !== exp) begin
         $display("Mismatch %s at cycle %0d: got %h expected %h", name, cyc, got, exp);
         mism++;
      end
   endtask

   task automatic check_reg(input string name, input dec_pkg::reg_addr_t got,
                            input dec_pkg::reg_addr_t exp);
      if (got !== exp) begin
         $display("Mismatch %s at cycle %0d: got %h expected %h", name, cyc, got, exp);
         mism++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch %s at cycle %0d: got %h expected %h", name, cyc, got, exp);
         mism++;
      end
   endtask

   task automatic check_cause(input string name, input dec_pkg::ecause_t got,
                              input dec_pkg::ecause_t exp);
      if (got !== exp) begin
         $display("Mismatch %s at cycle %0d: got %h expected %h", name, cyc, got, exp);
         mism++;
      end
   endtask

   // ********************
   // reference decode rules
   function automatic logic is_legal(input dec_pkg::instr_t x);
      logic hit;
      hit = 1'b0;
      foreach (OPCODES[i]) hit = hit | (x[6:0] == OPCODES[i]);
      return hit;
   endfunction

   function automatic logic reads_rs1(input dec_pkg::instr_t x);
      return is_legal(x) && x[6:0] != dec_pkg::op_lui && x[6:0] != dec_pkg::op_auipc
             && x[6:0] != dec_pkg::op_jal;
   endfunction

   function automatic logic reads_rs2(input dec_pkg::instr_t x);
      return x[6:0] == dec_pkg::op_branch || x[6:0] == dec_pkg::op_store
             || x[6:0] == dec_pkg::op_op;
   endfunction

   function automatic dec_pkg::reg_addr_t exp_rd(input dec_pkg::instr_t x);
      if (x[6:0] == dec_pkg::op_branch || x[6:0] == dec_pkg::op_store
          || x[6:0] == dec_pkg::op_fence)
         return '0;                                   // no destination
      return x[11:7];
   endfunction

   function automatic dec_pkg::data_t exp_imm(input dec_pkg::instr_t x);
      dec_pkg::data_t sx;
      dec_pkg::data_t imm;
      sx = dec_pkg::data_t'($signed(x) >>> 31);       // all ones if negative
      case (x[6:0])
         dec_pkg::op_lui, dec_pkg::op_auipc: imm = x & 32'hffff_f000;
         dec_pkg::op_jal: imm = (sx << 20) | (dec_pkg::data_t'(x[19:12]) << 12)
            | (dec_pkg::data_t'(x[20]) << 11) | (dec_pkg::data_t'(x[30:21]) << 1);
         dec_pkg::op_branch: imm = (sx << 12) | (dec_pkg::data_t'(x[7]) << 11)
            | (dec_pkg::data_t'(x[30:25]) << 5) | (dec_pkg::data_t'(x[11:8]) << 1);
         dec_pkg::op_store: imm = (sx << 11) | (dec_pkg::data_t'(x[30:25]) << 5)
            | dec_pkg::data_t'(x[11:7]);
         dec_pkg::op_op: imm = '0;
         default: imm = (sx << 11) | dec_pkg::data_t'(x[30:20]);  // I format
      endcase
      return imm;
   endfunction

   function automatic dec_pkg::ecause_t exp_cause(input logic f, input dec_pkg::instr_t x);
      if (f) return dec_pkg::CAUSE_ICAF;              // fault beats illegal
      return is_legal(x) ? 5'd0 : dec_pkg::CAUSE_ILLEGAL;
   endfunction

   function automatic dec_pkg::data_t exp_tval(input logic f, input dec_pkg::instr_t x,
                                                input dec_pkg::pc_t pc);
      return f ? {pc, 1'b0} : x;
   endfunction

   // ********************
   // stimulus helpers
   function automatic dec_pkg::instr_t rand_legal();
      dec_pkg::instr_t x;
      x = $urandom;
      x[6:0] = OPCODES[4'($urandom % 11)];
      return x;
   endfunction

   function automatic dec_pkg::instr_t rand_illegal();
      dec_pkg::instr_t x;
      x = $urandom;
      while (is_legal(x)) x = $urandom;
      return x;
   endfunction

   function automatic dec_pkg::instr_t op_rr(input dec_pkg::reg_addr_t rs1,
                                             input dec_pkg::reg_addr_t rs2);
      return {7'b0, rs2, rs1, 3'b000, rs1, dec_pkg::op_op};  // add rs1, rs1, rs2
   endfunction

   task automatic write_ports(input logic w0, input dec_pkg::reg_addr_t a0,
                              input dec_pkg::data_t d0, input logic w1,
                              input dec_pkg::reg_addr_t a1, input dec_pkg::data_t d1,
                              input logic w2, input dec_pkg::reg_addr_t a2,
                              input dec_pkg::data_t d2);
      dec_i0_wen_wb = w0;
      dec_i0_waddr_wb = a0;
      dec_i0_wdata_wb = d0;
      dec_i1_wen_wb = w1;
      dec_i1_waddr_wb = a1;
      dec_i1_wdata_wb = d1;
      dec_nonblock_load_wen = w2;
      dec_nonblock_load_waddr = a2;
      lsu_nonblock_load_data = d2;
   endtask

   task automatic drive_pair(input dec_pkg::instr_t x0, input dec_pkg::instr_t x1,
                             input logic v0, input logic v1, input logic f0,
                             input logic f1, input logic flush);
      pair_t p;
      ifu_i0_valid = v0;
      ifu_i1_valid = v1;
      ifu_i0_instr = x0;
      ifu_i1_instr = x1;
      ifu_i0_icaf = f0;
      ifu_i1_icaf = f1;
      ifu_i0_pc = dec_pkg::pc_t'($urandom);
      ifu_i1_pc = dec_pkg::pc_t'($urandom);
      exu_flush_final = flush;
      if (flush) tq.delete();                         // in flight pairs die
      if (v0 && !flush) begin
         p = '{i0: x0, i1: x1, pc0: ifu_i0_pc, pc1: ifu_i1_pc, v1: v1, f0: f0,
               f1: f1, due: cyc + 1};
         dq.push_back(p);
         p.due = cyc + 1 + dec_pkg::TRACE_DELAY;
         tq.push_back(p);
      end
   endtask

   task automatic random_pair();
      dec_pkg::instr_t x0;
      dec_pkg::instr_t x1;
      x0 = (($urandom % 100) < 10) ? rand_illegal() : rand_legal();
      x1 = (($urandom % 100) < 10) ? rand_illegal() : rand_legal();
      write_ports($urandom % 2 == 1, dec_pkg::reg_addr_t'($urandom), $urandom,
                  $urandom % 2 == 1, dec_pkg::reg_addr_t'($urandom), $urandom,
                  $urandom % 2 == 1, dec_pkg::reg_addr_t'($urandom), $urandom);
      drive_pair(x0, x1, ($urandom % 4) != 0, $urandom % 2 == 1,
                 ($urandom % 100) < 5, ($urandom % 100) < 5, ($urandom % 100) < 4);
   endtask

   // ********************
   // per cycle checks
   task automatic check_decode();
      pair_t p;
      while (dq.size() != 0 && dq[0].due < cyc) begin
         $display("decode result for pc %h missing at cycle %0d", {dq[0].pc0, 1'b0}, cyc);
         other++;
         void'(dq.pop_front());
      end
      if (dec_i0_valid_d === 1'b1) begin
         if (dq.size() == 0 || dq[0].due != cyc) begin
            $display("decode valid at cycle %0d without a strobe", cyc);
            other++;
         end else begin
            p = dq.pop_front();
            check_bit("dec_i1_valid_d", dec_i1_valid_d, p.v1);
            if (is_legal(p.i0)) begin
               check_reg("dec_i0_rd_d", dec_i0_rd_d, exp_rd(p.i0));
               check_data("dec_i0_immed_d", dec_i0_immed_d, exp_imm(p.i0));
            end
            check_data("gpr_i0_rs1_d", gpr_i0_rs1_d, reads_rs1(p.i0) ? mregs[p.i0[19:15]] : '0);
            check_data("gpr_i0_rs2_d", gpr_i0_rs2_d, reads_rs2(p.i0) ? mregs[p.i0[24:20]] : '0);
            if (p.v1 && is_legal(p.i1)) begin
               check_reg("dec_i1_rd_d", dec_i1_rd_d, exp_rd(p.i1));
               check_data("dec_i1_immed_d", dec_i1_immed_d, exp_imm(p.i1));
            end
            if (p.v1) begin
               check_data("gpr_i1_rs1_d", gpr_i1_rs1_d,
                          reads_rs1(p.i1) ? mregs[p.i1[19:15]] : '0);
               check_data("gpr_i1_rs2_d", gpr_i1_rs2_d,
                          reads_rs2(p.i1) ? mregs[p.i1[24:20]] : '0);
            end
         end
      end else begin
         check_bit("dec_i0_valid_d", dec_i0_valid_d, 1'b0);
         check_bit("dec_i1_valid_d", dec_i1_valid_d, 1'b0);  // never alone
      end
   endtask

   task automatic check_trace();
      pair_t p;
      logic e0;
      logic e1;
      while (tq.size() != 0 && tq[0].due < cyc) begin
         $display("trace for pc %h missing at cycle %0d", {tq[0].pc0, 1'b0}, cyc);
         other++;
         void'(tq.pop_front());
      end
      if (trace_valid !== 2'b00) begin
         if (tq.size() == 0 || tq[0].due != cyc) begin
            $display("trace valid %b at cycle %0d with no pair due", trace_valid, cyc);
            other++;
         end else begin
            p = tq.pop_front();
            e0 = p.f0 | ~is_legal(p.i0);
            e1 = p.v1 & (p.f1 | ~is_legal(p.i1));
            check_bit("trace_valid[0]", trace_valid[0], 1'b1);
            check_bit("trace_valid[1]", trace_valid[1], p.v1);
            check_bit("trace_exception[0]", trace_exception[0], e0);
            check_bit("trace_exception[1]", trace_exception[1], e1);
            check_data("trace_insn0", trace_insn0, p.i0);
            check_data("trace_addr0", trace_addr0, {p.pc0, 1'b0});
            if (p.v1) begin
               check_data("trace_insn1", trace_insn1, p.i1);
               check_data("trace_addr1", trace_addr1, {p.pc1, 1'b0});
            end
            // older excepting slot reports
            check_cause("trace_ecause", trace_ecause, e0 ? exp_cause(p.f0, p.i0)
                        : (e1 ? exp_cause(p.f1, p.i1) : 5'd0));
            check_data("trace_tval", trace_tval, e0 ? exp_tval(p.f0, p.i0, p.pc0)
                       : (e1 ? exp_tval(p.f1, p.i1, p.pc1) : '0));
         end
      end
   endtask

   // one clock: writes land in the model at the rising edge, checks at the falling edge
   task automatic cycle();
      @(posedge clk);
      cyc++;
      if (!rst_n) begin
         mregs = '{default: '0};
      end else begin
         if (dec_i0_wen_wb && dec_i0_waddr_wb != 5'd0) mregs[dec_i0_waddr_wb] = dec_i0_wdata_wb;
         if (dec_i1_wen_wb && dec_i1_waddr_wb != 5'd0) mregs[dec_i1_waddr_wb] = dec_i1_wdata_wb;
         if (dec_nonblock_load_wen && dec_nonblock_load_waddr != 5'd0)
            mregs[dec_nonblock_load_waddr] = lsu_nonblock_load_data;  // highest priority
      end
      @(negedge clk);
      check_decode();
      check_trace();
      ifu_i0_valid = 1'b0;            // back to idle
      ifu_i1_valid = 1'b0;
      exu_flush_final = 1'b0;
      write_ports(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0, '0);
   endtask

   task automatic drain();
      int guard;
      guard = 0;
      while (dq.size() != 0 || tq.size() != 0) begin
         cycle();
         guard++;
         if (guard > 10) begin
            $display("timeout: %0d decode and %0d trace results never appeared",
                     dq.size(), tq.size());
            other++;
            dq.delete();
            tq.delete();
         end
      end
   endtask

   // ********************
   // test sequence
   initial begin
      int k;
      dec_pkg::reg_addr_t a;
      dec_pkg::reg_addr_t b;
      dec_pkg::reg_addr_t c;
      dec_pkg::reg_addr_t d;
      void'($urandom(32'h4953));
      rst_n = 1'b0;
      exu_flush_final = 1'b0;
      drive_pair('0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      write_ports(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0, '0);
      repeat (8) cycle();
      rst_n = 1'b1;
      cycle();

      // x0 writes on every port, all 32 registers read back as zero
      for (k = 0; k < 16; k++) begin
         write_ports(1'b1, '0, $urandom, 1'b1, '0, $urandom, 1'b1, '0, $urandom);
         drive_pair(op_rr(5'(2 * k), 5'(2 * k + 1)), op_rr(5'(2 * k + 1), 5'(2 * k)),
                    1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
         cycle();
      end
      drain();

      // same address on all ports, then three distinct addresses
      a = dec_pkg::reg_addr_t'(1 + $urandom % 7);
      b = a + 5'd8;
      c = a + 5'd16;
      d = a + 5'd24;
      write_ports(1'b1, a, $urandom, 1'b1, a, $urandom, 1'b1, a, $urandom);
      cycle();
      write_ports(1'b1, b, $urandom, 1'b1, c, $urandom, 1'b1, d, $urandom);
      cycle();
      drive_pair(op_rr(a, b), op_rr(c, d), 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
      cycle();
      drain();

      // both slots except, slot 0 decides
      drive_pair(rand_illegal(), rand_legal(), 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
      cycle();
      drive_pair(rand_legal(), rand_illegal(), 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
      cycle();
      drain();

      // back to back pairs, flush with the third
      for (k = 0; k < 3; k++) begin
         drive_pair(rand_legal(), rand_legal(), 1'b1, 1'b1, 1'b0, 1'b0, k == 2);
         cycle();
      end
      repeat (4) cycle();             // nothing may trace here

      for (k = 0; k < 400; k++) begin
         random_pair();
         cycle();
      end
      drain();
      repeat (4) cycle();

      $display("errors: %0d mismatches, %0d other failures", mism, other);
      if (mism == 0 && other == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire
